//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = loopSequencer_tb
FILELIST = build.f
OBJDIR   = obj_dir
LOG      = sim.log
FAIL_MSG = Simulation finished: FAIL
PASS_MSG = Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Run ended early, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- build.f
+incdir+common
common/loop_pkg.sv
source/loopDecode.sv
loopStack/loopStackRam.sv
loopStack/loopStack.sv
source/loopExecute.sv
source/pcSequencer.sv
source/loopSequencer.sv
dv/loopSequencer_chk.sv
dv/loopSequencer_tb.sv

//--- common/loop_pkg.sv
`include "loop_settings.svh"

package loop_pkg;

  ////////////////////////////////////////
  // Opcodes and termination codes
  ////////////////////////////////////////

  // Instruction bits 15..12.
  typedef enum logic [3:0] {
    OP_NOP   = 4'h0,
    OP_DO    = 4'h1,  // Start a hardware loop.
    OP_LDCNT = 4'h2,  // Load the loop counter.
    OP_JUMP  = 4'h3,
    OP_POPLP = 4'h4   // Abandon the innermost loop.
  } opcode_e;

  // Instruction bits 11..9, zero-extended to four bits.
  typedef enum logic [3:0] {
    TC_FOREVER = 4'h0,
    TC_FLAG    = 4'h1,  // Ends on flagIn high at the loop end.
    TC_CE      = 4'h2   // Ends when the counter expires.
  } termCond_e;

  ////////////////////////////////////////
  // Structs
  ////////////////////////////////////////

  // One loop stack entry, 22 bits wide.
  typedef struct packed {
    logic [`LOOP_ADDR_W-1:0] startAddr;
    logic [`LOOP_ADDR_W-1:0] endAddr;
    termCond_e               cond;
  } loopEntry_t;

  typedef struct packed {
    opcode_e                 op;
    logic [`LOOP_ADDR_W-1:0] target;  // DO end address or JUMP destination.
    termCond_e               cond;
    logic [`LOOP_CNT_W-1:0]  count;   // LDCNT value.
  } decodedInstr_t;

endpackage

//--- common/loop_settings.svh
`ifndef LOOP_SETTINGS_SVH
`define LOOP_SETTINGS_SVH

////////////////////////////////////////
// Loop sequencer sizes
////////////////////////////////////////

// Program address width, shared by pc and the loop start and end fields.
`define LOOP_ADDR_W 9

// Entries in the hardware loop stack.
// The stack pointer carries one extra bit that marks the empty stack.
`define LOOP_DEPTH 4

// Loop counter width, the same as the LDCNT immediate.
`define LOOP_CNT_W 8

`endif

//--- dv/loopSequencer_chk.sv
`include "loop_settings.svh"

module loopSequencer_chk (
  input logic                             LPSCLK,
  input logic                             T_RST,
  input logic                             hold,
  input logic [$clog2(`LOOP_DEPTH):0]     ptr,
  input logic                             loopEmpty,
  input logic                             loopFull,
  input logic [`LOOP_ADDR_W-1:0]          pc,
  input logic                             isDo,
  input logic                             branchBack
);

  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////////////////////////
  // Stack pointer
  ////////////////////////////////////////

  fullAndEmpty: assert property (@(posedge LPSCLK) disable iff (T_RST)
    !(loopFull && loopEmpty))
    else $error("Loop stack flags full and empty at the same time");

  // Legal values are 0 to 3 and all ones for the empty stack.
  ptrRange: assert property (@(posedge LPSCLK) disable iff (T_RST)
    (ptr < `LOOP_DEPTH) || (ptr == '1))
    else $error("Loop stack pointer left its legal range, value %0d", ptr);

  ////////////////////////////////////////
  // Program counter
  ////////////////////////////////////////

  holdFreezesPc: assert property (@(posedge LPSCLK) disable iff (T_RST)
    hold |=> $stable(pc))
    else $error("pc moved while hold was high");

  doAtLoopEnd: assert property (@(posedge LPSCLK) disable iff (T_RST)
    isDo |-> !branchBack)  // Nested DO on the end address is unsupported.
    else $error("DO instruction placed at a loop end address");

endmodule

//--- dv/loopSequencer_tb.sv
`include "loop_settings.svh"

module loopSequencer_tb import loop_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int ClkHalf       = 20;
  localparam int ResetCycles   = 16;
  localparam int DriveDelay    = 2;
  localparam int ResetTimeout  = 64;
  localparam int FlagCap       = 40;
  localparam int FlagMinPasses = 2;
  localparam int RomDepth      = 1 << `LOOP_ADDR_W;
  localparam int TestReset     = 0;
  localparam int TestCount     = 1;
  localparam int TestFlag      = 2;
  localparam int TestNest      = 3;
  localparam int TestHold      = 4;
  localparam logic [`LOOP_ADDR_W-1:0] FlagStart = 9'd21;
  localparam logic [`LOOP_ADDR_W-1:0] FlagEnd   = 9'd22;
  localparam logic [`LOOP_ADDR_W-1:0] FlagExit  = 9'd23;

  // One cycle of stimulus and the outputs expected after the next edge.
  typedef struct packed {
    logic [2:0]              test;
    logic                    hold;
    logic                    flag;
    logic [`LOOP_ADDR_W-1:0] pc;
    logic                    empty;
    logic                    full;
    logic                    has1;
  } stimRow_t;

  logic                    LPSCLK = 1'b0;
  logic                    T_RST;
  logic                    hold;
  logic                    flagIn;
  logic [15:0]             instr;
  logic [`LOOP_ADDR_W-1:0] pc;
  logic                    loopEmpty;
  logic                    loopFull;
  logic                    loopHas1;

  logic [15:0] rom [RomDepth];
  stimRow_t    rows [$];
  string       testNames [5] = '{"reset and jump", "counted loop", "flag loop",
                                 "nesting", "hold"};
  int          errorCount  = 0;
  int          checkCount  = 0;
  int          testsPassed = 0;
  int          testsFailed = 0;
  int          testStart   = 0;
  logic [31:0] lfsr        = 32'h4e76_dc85;
  logic        resetOk;

  loopSequencer DUT (
    .LPSCLK   (LPSCLK),
    .T_RST    (T_RST),
    .hold     (hold),
    .instr    (instr),
    .flagIn   (flagIn),
    .pc       (pc),
    .loopEmpty(loopEmpty),
    .loopFull (loopFull),
    .loopHas1 (loopHas1)
  );

  bind loopStack loopSequencer_chk stackChk (
    .LPSCLK(LPSCLK), .T_RST(T_RST), .hold(hold), .ptr(ptr),
    .loopEmpty(loopEmpty), .loopFull(loopFull), .pc(9'd0),
    .isDo(1'b0), .branchBack(1'b0)
  );

  bind pcSequencer loopSequencer_chk pcChk (
    .LPSCLK(LPSCLK), .T_RST(T_RST), .hold(hold), .ptr(3'b111),
    .loopEmpty(1'b1), .loopFull(1'b0), .pc(pc),
    .isDo(dec.op == OP_DO), .branchBack(branchBack)
  );

  always #(ClkHalf) LPSCLK = ~LPSCLK;

  initial begin
    T_RST = 1'b1;
    repeat (ResetCycles) @(posedge LPSCLK);
    #1 T_RST = 1'b0;
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  // Taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic takeBit();
    lfsr = lfsrStep(lfsr);
    return lfsr[0];
  endfunction

  function automatic logic [15:0] encode(input opcode_e op, input termCond_e cond,
                                         input logic [8:0] field);
    return {op, cond[2:0], field};
  endfunction

  // Reference behavior of the flag loop body 21..22.
  function automatic logic [`LOOP_ADDR_W-1:0] flagLoopNext(
      input logic [`LOOP_ADDR_W-1:0] cur, input logic flag);
    if (cur == FlagEnd) begin
      return flag ? FlagExit : FlagStart;
    end
    return cur + 9'd1;
  endfunction

  function automatic void addRow(input int test, input int rowHold, input int rowFlag,
                                 input int rowPc, input int rowEmpty, input int rowFull,
                                 input int rowHas1);
    stimRow_t r;
    r.test  = 3'(test);
    r.hold  = 1'(rowHold);
    r.flag  = 1'(rowFlag);
    r.pc    = 9'(rowPc);
    r.empty = 1'(rowEmpty);
    r.full  = 1'(rowFull);
    r.has1  = 1'(rowHas1);
    rows.push_back(r);
  endfunction

  function automatic void addFlagRows();
    logic [`LOOP_ADDR_W-1:0] cur;
    logic [`LOOP_ADDR_W-1:0] next;
    logic                    flag;
    int                      passes;
    cur    = FlagStart;
    passes = 0;
    while (cur != FlagExit && passes < FlagCap) begin
      flag = takeBit();  // Off the end address the flag must have no effect.
      if (cur == FlagEnd && passes < FlagMinPasses) begin
        flag = 1'b0;  // The first passes always branch back, so the body repeats.
      end
      next = flagLoopNext(cur, flag);
      addRow(TestFlag, 0, int'(flag), int'(next), int'(next == FlagExit), 0,
             int'(next != FlagExit));
      if (cur == FlagEnd) begin
        passes++;
      end
      cur = next;
    end
  endfunction

  function automatic void buildRom();
    for (int a = 0; a < RomDepth; a++) begin
      rom[a] = {OP_NOP, 3'b000, 9'(a)};
    end
    rom[2]  = encode(OP_JUMP, TC_FOREVER, 9'd16);
    rom[16] = encode(OP_LDCNT, TC_FOREVER, 9'd3);
    rom[17] = encode(OP_DO, TC_CE, 9'd19);
    rom[20] = encode(OP_DO, TC_FLAG, FlagEnd);
    rom[23] = encode(OP_JUMP, TC_FOREVER, 9'd32);
    for (int k = 0; k < 5; k++) begin
      rom[32 + k] = encode(OP_DO, TC_FOREVER, 9'(60 - k));  // The fifth one is dropped.
    end
    for (int k = 0; k < 4; k++) begin
      rom[37 + k] = encode(OP_POPLP, TC_FOREVER, 9'd0);
    end
    rom[41] = encode(OP_JUMP, TC_FOREVER, 9'd64);
    rom[64] = encode(OP_LDCNT, TC_FOREVER, 9'd2);
    rom[65] = encode(OP_DO, TC_CE, 9'd67);
    rom[68] = encode(OP_JUMP, TC_FOREVER, 9'd68);
  endfunction

  // Each row holds test, hold and flagIn, then the expected pc and flags.
  function automatic void buildTable();
    addRow(TestReset, 0, 0,  1, 1, 0, 0);
    addRow(TestReset, 0, 0,  2, 1, 0, 0);
    addRow(TestReset, 0, 0, 16, 1, 0, 0);
    addRow(TestCount, 0, 0, 17, 1, 0, 0);
    addRow(TestCount, 0, 0, 18, 0, 0, 1);
    addRow(TestCount, 0, 0, 19, 0, 0, 1);
    addRow(TestCount, 0, 1, 18, 0, 0, 1);  // Flag is ignored by a counted loop.
    addRow(TestCount, 0, 0, 19, 0, 0, 1);
    addRow(TestCount, 0, 0, 18, 0, 0, 1);
    addRow(TestCount, 0, 0, 19, 0, 0, 1);
    addRow(TestCount, 0, 0, 20, 1, 0, 0);
    addRow(TestFlag,  0, 0, 21, 0, 0, 1);
    addFlagRows();
    addRow(TestFlag,  0, 0, 32, 1, 0, 0);
    addRow(TestNest,  0, 0, 33, 0, 0, 1);
    addRow(TestNest,  0, 0, 34, 0, 0, 0);
    addRow(TestNest,  0, 0, 35, 0, 0, 0);
    addRow(TestNest,  0, 0, 36, 0, 1, 0);
    addRow(TestNest,  0, 0, 37, 0, 1, 0);
    addRow(TestNest,  0, 0, 38, 0, 0, 0);
    addRow(TestNest,  0, 0, 39, 0, 0, 0);
    addRow(TestNest,  0, 0, 40, 0, 0, 1);
    addRow(TestNest,  0, 0, 41, 1, 0, 0);
    addRow(TestNest,  0, 0, 64, 1, 0, 0);
    addRow(TestHold,  0, 0, 65, 1, 0, 0);
    addRow(TestHold,  0, 0, 66, 0, 0, 1);
    addRow(TestHold,  0, 0, 67, 0, 0, 1);
    addRow(TestHold,  0, 0, 66, 0, 0, 1);
    addRow(TestHold,  0, 0, 67, 0, 0, 1);
    addRow(TestHold,  1, 0, 67, 0, 0, 1);
    addRow(TestHold,  1, 1, 67, 0, 0, 1);
    addRow(TestHold,  1, 0, 67, 0, 0, 1);
    addRow(TestHold,  0, 0, 68, 1, 0, 0);
    addRow(TestHold,  0, 0, 68, 1, 0, 0);
  endfunction

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("ERROR at %t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
    end
  endtask

  task automatic waitResetRelease(output logic ok);
    int cycles;
    ok     = 1'b0;
    cycles = 0;
    while (!ok && cycles < ResetTimeout) begin
      @(posedge LPSCLK);
      #DriveDelay;
      ok = (T_RST == 1'b0);
      cycles++;
    end
  endtask

  task automatic applyRow(input stimRow_t r);
    hold   = r.hold;
    flagIn = r.flag;
    instr  = rom[pc];
    @(posedge LPSCLK);
    #DriveDelay;
    check("pc", 32'(r.pc), 32'(pc));
    check("loopEmpty", 32'(r.empty), 32'(loopEmpty));
    check("loopFull", 32'(r.full), 32'(loopFull));
    check("loopHas1", 32'(r.has1), 32'(loopHas1));
  endtask

  task automatic reportTest(input int test);
    int errs;
    errs = errorCount - testStart;
    if (errs == 0) begin
      testsPassed++;
    end else begin
      testsFailed++;
    end
    $display("Test %0d (%s): %s, %0d errors", test + 1, testNames[test],
             (errs == 0) ? "passed" : "failed", errs);
    testStart = errorCount;
  endtask

  initial begin
    hold   = 1'b0;
    flagIn = 1'b0;
    $timeformat(-9, 1, " ns", 10);
    buildRom();
    buildTable();
    instr = rom[0];
    waitResetRelease(resetOk);
    if (!resetOk) begin
      $display("Reset was still asserted after %0d clock cycles", ResetTimeout);
      $display("Simulation finished: FAIL");
    end else begin
      check("pc", 32'd0, 32'(pc));
      check("loopEmpty", 32'd1, 32'(loopEmpty));
      check("loopFull", 32'd0, 32'(loopFull));
      check("loopHas1", 32'd0, 32'(loopHas1));
      for (int i = 0; i < rows.size(); i++) begin
        applyRow(rows[i]);
        if (i == rows.size() - 1 || rows[i + 1].test != rows[i].test) begin
          reportTest(int'(rows[i].test));
        end
      end
      $display("Tests passed: %0d, failed: %0d, checks: %0d, errors: %0d",
               testsPassed, testsFailed, checkCount, errorCount);
      if (errorCount == 0) begin
        $display("Simulation finished: PASS");
      end else begin
        $display("Simulation finished: FAIL");
      end
    end
    $finish;
  end

endmodule

//--- loopStack/loopStack.sv
`include "loop_settings.svh"

module loopStack import loop_pkg::*; (
  input  logic       LPSCLK,
  input  logic       T_RST,
  input  logic       hold,
  input  logic       pushEn,
  input  logic       popEn,
  input  loopEntry_t pushEntry,
  output loopEntry_t topEntry,
  output logic       loopEmpty,
  output logic       loopFull,
  output logic       loopHas1
);

  localparam int AddrW = $clog2(`LOOP_DEPTH);
  localparam int PtrW  = AddrW + 1;

  logic [PtrW-1:0]  ptr;
  logic [PtrW-1:0]  ptrInc;
  logic [PtrW-1:0]  ptrDec;
  logic             push;
  logic             pop;
  logic             we;

  ////////////////////////////////////////
  // Pointer
  ////////////////////////////////////////

  // Requests against a full or empty stack are dropped here.
  assign push = pushEn && !loopFull;
  assign pop  = popEn && !loopEmpty;

  assign ptrInc = ptr + 1'b1;
  assign ptrDec = ptr - 1'b1;

  // All ones is the empty stack, so the first push lands in entry 0.
  always_ff @(posedge LPSCLK or posedge T_RST) begin
    if (T_RST) begin
      ptr <= '1;
    end else if (!hold && (push || pop)) begin
      ptr <= push ? ptrInc : ptrDec;
    end
  end

  assign loopEmpty = ptr[PtrW-1];
  assign loopFull  = (ptr == PtrW'(`LOOP_DEPTH - 1));
  assign loopHas1  = (ptr == '0);

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  assign we = push && !hold;  // Hold freezes the array too.

  loopStackRam stackRam (
    .LPSCLK(LPSCLK),
    .we    (we),
    .wa    (ptrInc[AddrW-1:0]),
    .wd    (pushEntry),
    .ra    (ptr[AddrW-1:0]),
    .rd    (topEntry)
  );

endmodule

//--- loopStack/loopStackRam.sv
`include "loop_settings.svh"

module loopStackRam import loop_pkg::*; (
  input  logic                            LPSCLK,
  input  logic                            we,
  input  logic [$clog2(`LOOP_DEPTH)-1:0]  wa,
  input  loopEntry_t                      wd,
  input  logic [$clog2(`LOOP_DEPTH)-1:0]  ra,
  output loopEntry_t                      rd
);

  loopEntry_t cells [`LOOP_DEPTH];

  // Single write port, written on the clock edge.
  always_ff @(posedge LPSCLK) begin
    if (we) begin
      cells[wa] <= wd;
    end
  end

  // The read port is combinational so the top entry is seen at once.
  assign rd = cells[ra];

endmodule

//--- source/loopDecode.sv
`include "loop_settings.svh"

module loopDecode import loop_pkg::*; (
  input  logic [15:0]   instr,
  output decodedInstr_t dec
);

  logic [3:0] opField;
  logic [3:0] condField;

  assign opField   = instr[15:12];
  assign condField = {1'b0, instr[11:9]};  // Three bits in the word.

  // Unknown opcodes fall back to NOP.
  always_comb begin
    case (opField)
      OP_DO,
      OP_LDCNT,
      OP_JUMP,
      OP_POPLP: begin
        dec.op = opcode_e'(opField);
      end
      default: begin
        dec.op = OP_NOP;
      end
    endcase
  end

  // Unknown termination codes behave as a loop that never ends.
  always_comb begin
    case (condField)
      TC_FLAG,
      TC_CE: begin
        dec.cond = termCond_e'(condField);
      end
      default: begin
        dec.cond = TC_FOREVER;
      end
    endcase
  end

  // The target and count fields overlap, each opcode reads its own.
  assign dec.target = instr[`LOOP_ADDR_W-1:0];
  assign dec.count  = instr[`LOOP_CNT_W-1:0];

endmodule

//--- source/loopExecute.sv
`include "loop_settings.svh"

module loopExecute import loop_pkg::*; (
  input  logic                     LPSCLK,
  input  logic                     T_RST,
  input  logic                     hold,
  input  logic [`LOOP_ADDR_W-1:0]  pc,
  input  decodedInstr_t            dec,
  input  logic                     flagIn,
  input  loopEntry_t               topEntry,
  input  logic                     loopEmpty,
  output logic                     pushEn,
  output logic                     popEn,
  output loopEntry_t               pushEntry,
  output logic                     branchBack
);

  logic [`LOOP_CNT_W-1:0]  loopCnt;
  logic [`LOOP_ADDR_W-1:0] nextAddr;
  logic                    loopEnd;
  logic                    terminate;
  logic                    cntDec;

  ////////////////////////////////////////
  // Loop end and terminate decision
  ////////////////////////////////////////

  // A JUMP at the end address leaves the loop without a test.
  assign loopEnd = !loopEmpty && (pc == topEntry.endAddr) && (dec.op != OP_JUMP);

  always_comb begin
    case (topEntry.cond)
      TC_FLAG: begin
        terminate = flagIn;
      end
      TC_CE: begin
        terminate = (loopCnt == `LOOP_CNT_W'(1));  // Last pass of the body.
      end
      default: begin
        terminate = 1'b0;
      end
    endcase
  end

  assign branchBack = loopEnd && !terminate;

  ////////////////////////////////////////
  // Stack controls
  ////////////////////////////////////////

  assign nextAddr = pc + 1'b1;

  // The body starts right after the DO.
  assign pushEn          = (dec.op == OP_DO);
  assign pushEntry.startAddr = nextAddr;
  assign pushEntry.endAddr   = dec.target;
  assign pushEntry.cond      = dec.cond;

  assign popEn = (loopEnd && terminate) || (dec.op == OP_POPLP);

  ////////////////////////////////////////
  // Loop counter
  ////////////////////////////////////////

  assign cntDec = loopEnd && (topEntry.cond == TC_CE);

  // A load wins over a decrement in the same cycle. The count stops at zero.
  always_ff @(posedge LPSCLK or posedge T_RST) begin
    if (T_RST) begin
      loopCnt <= '0;
    end else if (!hold) begin
      if (dec.op == OP_LDCNT) begin
        loopCnt <= dec.count;
      end else if (cntDec && (loopCnt != '0)) begin
        loopCnt <= loopCnt - 1'b1;
      end
    end
  end

endmodule

//--- source/loopSequencer.sv
`include "loop_settings.svh"

module loopSequencer import loop_pkg::*; (
  input  logic                     LPSCLK,
  input  logic                     T_RST,
  input  logic                     hold,
  input  logic [15:0]              instr,
  input  logic                     flagIn,
  output logic [`LOOP_ADDR_W-1:0]  pc,
  output logic                     loopEmpty,
  output logic                     loopFull,
  output logic                     loopHas1
);

  decodedInstr_t dec;
  loopEntry_t    pushEntry;
  loopEntry_t    topEntry;
  logic          pushEn;
  logic          popEn;
  logic          branchBack;

  loopDecode decode (
    .instr(instr),
    .dec  (dec)
  );

  loopExecute execute (
    .LPSCLK    (LPSCLK),
    .T_RST     (T_RST),
    .hold      (hold),
    .pc        (pc),
    .dec       (dec),
    .flagIn    (flagIn),
    .topEntry  (topEntry),
    .loopEmpty (loopEmpty),
    .pushEn    (pushEn),
    .popEn     (popEn),
    .pushEntry (pushEntry),
    .branchBack(branchBack)
  );

  loopStack stack (
    .LPSCLK   (LPSCLK),
    .T_RST    (T_RST),
    .hold     (hold),
    .pushEn   (pushEn),
    .popEn    (popEn),
    .pushEntry(pushEntry),
    .topEntry (topEntry),
    .loopEmpty(loopEmpty),
    .loopFull (loopFull),
    .loopHas1 (loopHas1)
  );

  // Only the start address of the top entry reaches the PC logic.
  pcSequencer sequencer (
    .LPSCLK    (LPSCLK),
    .T_RST     (T_RST),
    .hold      (hold),
    .dec       (dec),
    .branchBack(branchBack),
    .startAddr (topEntry.startAddr),
    .pc        (pc)
  );

endmodule

//--- source/pcSequencer.sv
`include "loop_settings.svh"

module pcSequencer import loop_pkg::*; (
  input  logic                     LPSCLK,
  input  logic                     T_RST,
  input  logic                     hold,
  input  decodedInstr_t            dec,
  input  logic                     branchBack,
  input  logic [`LOOP_ADDR_W-1:0]  startAddr,
  output logic [`LOOP_ADDR_W-1:0]  pc
);

  logic [`LOOP_ADDR_W-1:0] pcNext;

  ////////////////////////////////////////
  // Next address
  ////////////////////////////////////////

  // JUMP first, then the loop branch, then the sequential address.
  always_comb begin
    if (dec.op == OP_JUMP) begin
      pcNext = dec.target;
    end else if (branchBack) begin
      pcNext = startAddr;
    end else begin
      pcNext = pc + 1'b1;  // Wraps at the top of program space.
    end
  end

  ////////////////////////////////////////
  // PC register
  ////////////////////////////////////////

  always_ff @(posedge LPSCLK or posedge T_RST) begin
    if (T_RST) begin
      pc <= '0;
    end else if (!hold) begin
      pc <= pcNext;
    end
  end

endmodule
